// File: rtl/line_lcd_pkg.sv
package line_lcd_pkg;

  // ************************************************************
  // host side

  // byte address whose write kicks off a plot (color low byte)
  localparam logic [7:0] C_PLOT_ADDR = 8'd9;

  // one host register write
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } reg_wr_t;

  // latched line request, 80 bits
  typedef struct packed {
    logic [15:0] x0;
    logic [15:0] y0;
    logic [15:0] x1;
    logic [15:0] y1;
    logic [15:0] color;   // rgb565
  } line_cmd_t;

  // ************************************************************
  // line path to display

  // one horizontal or vertical run
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] len;      // pixel count, never 0
    logic        vertical; // 0 runs along x, 1 along y
    logic [15:0] color;
  } hv_seg_t;

  // one byte for the display serializer
  typedef struct packed {
    logic [7:0] data;
    logic       dc;   // 0 command, 1 data
  } lcd_byte_t;

  // st7789 opcodes in use
  typedef enum logic [7:0] {
    OP_CASET = 8'h2A,
    OP_RASET = 8'h2B,
    OP_RAMWR = 8'h2C
  } lcd_op_e;

  typedef enum logic [2:0] {L_IDLE, L_SETUP, L_WALK, L_EMIT, L_WAIT_SEG} line_state_e;

  typedef enum logic [2:0] {S_IDLE, S_CMD, S_ARG, S_PIX, S_DONE_WAIT} seg_state_e;

endpackage

// File: rtl/spi_reg_slave.sv
`timescale 1ns/10ps

// mode 0 write-only register port, host sclk at most clk/8
module spi_reg_slave import line_lcd_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    spi_csn,
  input  logic    spi_sclk,
  input  logic    spi_mosi,
  output logic    wr,
  output reg_wr_t wr_data
);

  logic [1:0] csn_q;    // two-flop synchronizers
  logic [2:0] sclk_q;   // extra stage for edge detect
  logic [1:0] mosi_q;
  logic       sclk_rise;
  logic [2:0] bit_cnt;
  logic       first;    // next byte is the address
  logic       got_byte; // shift holds a full byte
  logic       wr_pend;
  logic [7:0] addr;
  logic [7:0] shift;

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      csn_q    <= 2'b11;
      sclk_q   <= '0;
      mosi_q   <= '0;
      bit_cnt  <= '0;
      first    <= 1'b1;
      got_byte <= 1'b0;
      wr_pend  <= 1'b0;
      wr       <= 1'b0;
      addr     <= '0;
    end
    else
    begin
      csn_q    <= {csn_q[0], spi_csn};
      sclk_q   <= {sclk_q[1:0], spi_sclk};
      mosi_q   <= {mosi_q[0], spi_mosi};
      got_byte <= 1'b0;
      wr_pend  <= 1'b0;
      wr       <= wr_pend;          // 3rd cycle after the 8th edge
      if (wr_pend)
        addr <= addr + 8'd1;        // auto increment
      if (csn_q[1])
      begin
        bit_cnt <= '0;              // frame boundary
        first   <= 1'b1;
      end
      else if (sclk_rise)
      begin
        bit_cnt  <= bit_cnt + 3'd1;
        got_byte <= (bit_cnt == 3'd7);
      end
      if (got_byte)
      begin
        if (first)
        begin
          addr  <= shift;           // start address
          first <= 1'b0;
        end
        else
          wr_pend <= 1'b1;
      end
    end
  end

  // msb first shifter and write payload
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift <= {shift[6:0], mosi_q[1]};
    if (got_byte)
      wr_data <= '{addr: addr, data: shift};
  end

endmodule

// File: rtl/line_regs.sv
`timescale 1ns/10ps

// ten byte parameter bank, high byte first per field
module line_regs import line_lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      wr,
  input  reg_wr_t   wr_data,
  input  logic      busy,
  output logic      plot,
  output line_cmd_t cmd
);

  logic [7:0] regs [0:9];
  logic       hit;

  // a plot request while drawing is dropped
  assign hit = wr && (wr_data.addr == C_PLOT_ADDR) && !busy;

  always_ff @(posedge clk)
  begin
    if (wr && (wr_data.addr < 8'd10))
      regs[wr_data.addr[3:0]] <= wr_data.data;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      plot <= 1'b0;
    else
      plot <= hit;   // one cycle after the color low byte lands
  end

  // byte 0 is x0 high, byte 9 is color low
  assign cmd = '{
    x0:    {regs[0], regs[1]},
    y0:    {regs[2], regs[3]},
    x1:    {regs[4], regs[5]},
    y1:    {regs[6], regs[7]},
    color: {regs[8], regs[9]}
  };

endmodule

// File: rtl/draw_line.sv
`timescale 1ns/10ps

// bresenham walker that splits a line into h or v runs
module draw_line import line_lcd_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      plot,
  input  line_cmd_t cmd,
  output logic      busy,
  output logic      seg_plot,
  output hv_seg_t   seg,
  input  logic      seg_busy
);

  line_state_e        state;
  line_cmd_t          c;          // request copy as the host may rewrite regs
  logic [15:0]        dx, dy, dmj_c, dmn_c;
  logic [15:0]        sx, sy, ex, ey;
  logic               x_major_c, swap_c;
  logic               x_major, step_neg, last_run;
  logic [15:0]        maj, mnr, maj_end, d_maj, d_mnr;
  logic [15:0]        run_maj, run_mnr, run_len;
  logic signed [18:0] err;

  // ************************************************************
  // setup math orders the endpoints so the major axis counts up
  always_comb
  begin
    dx        = (c.x1 >= c.x0) ? c.x1 - c.x0 : c.x0 - c.x1;
    dy        = (c.y1 >= c.y0) ? c.y1 - c.y0 : c.y0 - c.y1;
    x_major_c = (dx >= dy);   // ties go horizontal
    swap_c    = x_major_c ? (c.x1 < c.x0) : (c.y1 < c.y0);
    sx        = swap_c ? c.x1 : c.x0;
    sy        = swap_c ? c.y1 : c.y0;
    ex        = swap_c ? c.x0 : c.x1;
    ey        = swap_c ? c.y0 : c.y1;
    dmj_c     = x_major_c ? dx : dy;
    dmn_c     = x_major_c ? dy : dx;
  end

  assign seg_plot = (state == L_EMIT) && !seg_busy;
  assign seg = '{
    x:        x_major ? run_maj : run_mnr,
    y:        x_major ? run_mnr : run_maj,
    len:      run_len,
    vertical: !x_major,
    color:    c.color
  };

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= L_IDLE;
      busy  <= 1'b0;
    end
    else
      case (state)
        L_IDLE:
          if (plot)
          begin
            busy  <= 1'b1;
            state <= L_SETUP;
          end
        L_SETUP:    state <= L_WALK;
        L_WALK:     if ((maj == maj_end) || (err > 19'sd0)) state <= L_EMIT;
        L_EMIT:     if (!seg_busy) state <= L_WAIT_SEG;
        L_WAIT_SEG:
          if (!seg_busy)
          begin
            state <= last_run ? L_IDLE : L_WALK;
            busy  <= !last_run;   // drops once the final run is out
          end
        default:    state <= L_IDLE;
      endcase
  end

  // ************************************************************
  // walker datapath stepping one pixel per cycle
  always_ff @(posedge clk)
  begin
    case (state)
      L_IDLE: if (plot) c <= cmd;
      L_SETUP:
      begin
        x_major  <= x_major_c;
        maj      <= x_major_c ? sx : sy;
        mnr      <= x_major_c ? sy : sx;
        maj_end  <= x_major_c ? ex : ey;
        d_maj    <= dmj_c;
        d_mnr    <= dmn_c;
        step_neg <= x_major_c ? (ey < sy) : (ex < sx);
        err      <= $signed({2'b00, dmn_c, 1'b0}) - $signed({3'b000, dmj_c}); // 2dmin - dmaj
        run_maj  <= x_major_c ? sx : sy;
        run_mnr  <= x_major_c ? sy : sx;
        run_len  <= 16'd1;
        last_run <= 1'b0;
      end
      L_WALK:
        if (maj == maj_end)
          last_run <= 1'b1;       // end pixel closes the run
        else
        begin
          maj <= maj + 16'd1;
          if (err > 19'sd0)
          begin
            mnr <= step_neg ? mnr - 16'd1 : mnr + 16'd1;
            err <= err + $signed({2'b00, d_mnr, 1'b0}) - $signed({2'b00, d_maj, 1'b0});
          end
          else
          begin
            err     <= err + $signed({2'b00, d_mnr, 1'b0});
            run_len <= run_len + 16'd1;   // grow the run while minor holds
          end
        end
      L_EMIT:
        if (!seg_busy)
        begin
          run_maj <= maj;   // next run starts at the stepped pixel
          run_mnr <= mnr;
          run_len <= 16'd1;
        end
      default: ;
    endcase
  end

endmodule

// File: rtl/lcd_spi_tx.sv
`timescale 1ns/10ps

// byte serializer, sclk idles high, mosi moves on falling edges
module lcd_spi_tx import line_lcd_pkg::*;
#(
  parameter int clk_div = 2
)
(
  input  logic      clk,
  input  logic      reset,
  input  logic      tx_start,
  input  lcd_byte_t tx_byte,
  output logic      tx_busy,
  output logic      lcd_sclk,
  output logic      lcd_mosi,
  output logic      lcd_dc,
  output logic      lcd_csn
);

  localparam int DIV_W = (clk_div > 1) ? $clog2(clk_div) : 1;

  logic [DIV_W-1:0] div_cnt;
  logic [4:0]       half_cnt;  // 16 half periods, then release
  logic [7:0]       shift;
  logic             tick;

  assign tick     = (div_cnt == DIV_W'(clk_div - 1));
  assign lcd_mosi = shift[7];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tx_busy  <= 1'b0;
      lcd_csn  <= 1'b1;
      lcd_sclk <= 1'b1;
      lcd_dc   <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        tx_busy  <= 1'b1;
        lcd_csn  <= 1'b0;
        lcd_dc   <= tx_byte.dc;          // held for the whole byte
        div_cnt  <= DIV_W'(clk_div - 1); // first edge after one lead cycle
        half_cnt <= '0;
      end
    end
    else if (tick)
    begin
      div_cnt <= '0;
      if (half_cnt == 5'd16)
      begin
        tx_busy <= 1'b0;
        lcd_csn <= 1'b1;
      end
      else
      begin
        lcd_sclk <= !lcd_sclk;
        half_cnt <= half_cnt + 5'd1;
      end
    end
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // bit 7 is out before the first fall, later falls shift
  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
      shift <= tx_byte.data;
    else if (tx_busy && tick && lcd_sclk && (half_cnt != 5'd0) && (half_cnt != 5'd16))
      shift <= {shift[6:0], 1'b0};
  end

endmodule

// File: rtl/lcd_hvline.sv
`timescale 1ns/10ps

// window setup plus pixel burst for one run
module lcd_hvline import line_lcd_pkg::*;
#(
  parameter int clk_div = 2
)
(
  input  logic    clk,
  input  logic    reset,
  input  logic    seg_plot,
  input  hv_seg_t seg,
  output logic    seg_busy,
  output logic    lcd_sclk,
  output logic    lcd_mosi,
  output logic    lcd_dc,
  output logic    lcd_csn,
  output logic    lcd_resn
);

  seg_state_e  state;
  hv_seg_t     s;
  logic [3:0]  byte_idx;  // 0 caset, 1-4 args, 5 raset, 6-9 args, 10 ramwr
  logic [15:0] pix_cnt;
  logic        pix_lo;    // low byte of the color word next
  logic [15:0] x_end, y_end;
  logic [31:0] win;
  logic [1:0]  arg_sel;
  lcd_op_e     op;
  lcd_byte_t   tx_byte;
  logic        tx_start, tx_busy;

  assign lcd_resn = 1'b1;   // no hw reset sequence
  assign x_end = s.vertical ? s.x : s.x + s.len - 16'd1;
  assign y_end = s.vertical ? s.y + s.len - 16'd1 : s.y;
  assign tx_start = !tx_busy && ((state == S_CMD) || (state == S_ARG) || (state == S_PIX));

  always_comb
  begin
    win     = (byte_idx < 4'd5) ? {s.x, x_end} : {s.y, y_end};
    arg_sel = (byte_idx < 4'd5) ? 2'(byte_idx - 4'd1) : 2'(byte_idx - 4'd6);
    case (byte_idx)
      4'd0:    op = OP_CASET;
      4'd5:    op = OP_RASET;
      default: op = OP_RAMWR;
    endcase
    case (state)
      S_CMD:   tx_byte = '{data: op, dc: 1'b0};
      S_ARG:   tx_byte = '{data: win[31 - 8*arg_sel -: 8], dc: 1'b1};  // start then end, msb first
      default: tx_byte = '{data: pix_lo ? s.color[7:0] : s.color[15:8], dc: 1'b1};
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= S_IDLE;
      seg_busy <= 1'b0;
      byte_idx <= '0;
      pix_cnt  <= '0;
      pix_lo   <= 1'b0;
    end
    else
      case (state)
        S_IDLE:
          if (seg_plot)
          begin
            seg_busy <= 1'b1;
            byte_idx <= '0;
            pix_cnt  <= '0;
            pix_lo   <= 1'b0;
            state    <= S_CMD;
          end
        S_CMD:
          if (tx_start)
          begin
            byte_idx <= byte_idx + 4'd1;
            state    <= (byte_idx == 4'd10) ? S_PIX : S_ARG;
          end
        S_ARG:
          if (tx_start)
          begin
            byte_idx <= byte_idx + 4'd1;
            if ((byte_idx == 4'd4) || (byte_idx == 4'd9))
              state <= S_CMD;
          end
        S_PIX:
          if (tx_start)
          begin
            pix_lo <= !pix_lo;
            if (pix_lo)
            begin
              if (pix_cnt == s.len - 16'd1)
                state <= S_DONE_WAIT;   // last word queued
              else
                pix_cnt <= pix_cnt + 16'd1;
            end
          end
        S_DONE_WAIT:
          if (!tx_busy)
          begin
            seg_busy <= 1'b0;
            state    <= S_IDLE;
          end
        default: state <= S_IDLE;
      endcase
  end

  always_ff @(posedge clk)
  begin
    if ((state == S_IDLE) && seg_plot)
      s <= seg;
  end

  lcd_spi_tx #(
    .clk_div (clk_div)
  ) u_lcd_spi_tx (
    .clk      (clk),
    .reset    (reset),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .lcd_sclk (lcd_sclk),
    .lcd_mosi (lcd_mosi),
    .lcd_dc   (lcd_dc),
    .lcd_csn  (lcd_csn)
  );

endmodule

// File: rtl/line_lcd_top.sv
`timescale 1ns/10ps

// host spi -> regs -> bresenham -> st7789 window writer
module line_lcd_top import line_lcd_pkg::*;
#(
  parameter int clk_div = 2   // display sclk half period in clk cycles
)
(
  input  logic clk,
  input  logic reset,
  input  logic spi_csn,
  input  logic spi_sclk,
  input  logic spi_mosi,
  output logic busy,
  output logic lcd_sclk,
  output logic lcd_mosi,
  output logic lcd_dc,
  output logic lcd_csn,
  output logic lcd_resn
);

  logic      wr;
  reg_wr_t   wr_data;
  logic      plot;
  line_cmd_t cmd;
  logic      seg_plot, seg_busy;
  hv_seg_t   seg;

  // ************************************************************
  spi_reg_slave u_spi_reg_slave (
    .clk (clk), .reset (reset),
    .spi_csn (spi_csn), .spi_sclk (spi_sclk), .spi_mosi (spi_mosi),
    .wr (wr), .wr_data (wr_data)
  );

  line_regs u_line_regs (
    .clk (clk), .reset (reset),
    .wr (wr), .wr_data (wr_data),
    .busy (busy), .plot (plot), .cmd (cmd)
  );

  draw_line u_draw_line (
    .clk (clk), .reset (reset),
    .plot (plot), .cmd (cmd), .busy (busy),
    .seg_plot (seg_plot), .seg (seg), .seg_busy (seg_busy)
  );

  lcd_hvline #(.clk_div (clk_div)) u_lcd_hvline (
    .clk (clk), .reset (reset),
    .seg_plot (seg_plot), .seg (seg), .seg_busy (seg_busy),
    .lcd_sclk (lcd_sclk), .lcd_mosi (lcd_mosi), .lcd_dc (lcd_dc),
    .lcd_csn (lcd_csn), .lcd_resn (lcd_resn)
  );

endmodule

// File: tb/line_lcd_checker.sv
`timescale 1ns/10ps

// protocol rules on the line path bound into line_lcd_top
module line_lcd_checker
(
  input logic clk,
  input logic reset,
  input logic busy,
  input logic seg_plot,
  input logic seg_busy,
  input logic lcd_csn,
  input logic lcd_dc,
  input logic lcd_resn
);

  // ************************************************************
  // idle outputs one cycle into the synchronous reset
  reset_idle: assert property (@(posedge clk) reset |=> (lcd_csn && !busy))
    else $error("lcd_csn low or busy high during reset");

  // the writer takes each run and no second run follows while it is busy
  seg_handshake: assert property (@(posedge clk) disable iff (reset)
    seg_plot |=> (seg_busy && !seg_plot))
    else $error("seg_plot not taken by the writer or pulsed again while seg_busy was high");

  // dc held for the whole byte
  dc_stable: assert property (@(posedge clk) disable iff (reset)
    !lcd_csn |=> (lcd_csn || $stable(lcd_dc)))
    else $error("lcd_dc changed in the middle of a display byte");

  resn_high: assert property (@(posedge clk) lcd_resn)   // no hw reset pulses
    else $error("lcd_resn went low");

endmodule

bind line_lcd_top line_lcd_checker u_line_lcd_checker (
  .clk      (clk),
  .reset    (reset),
  .busy     (busy),
  .seg_plot (seg_plot),
  .seg_busy (seg_busy),
  .lcd_csn  (lcd_csn),
  .lcd_dc   (lcd_dc),
  .lcd_resn (lcd_resn)
);

// File: tb/tb_line_lcd.sv
`timescale 1ns/10ps

module tb_line_lcd import line_lcd_pkg::*;
();

  localparam int clk_div = 2;
  localparam int n_lines = 14;
  localparam int byte_cycles = 16 * clk_div + 3;   // one display byte plus gap

  logic        clk, reset;
  logic        spi_csn, spi_sclk, spi_mosi;
  logic        busy, lcd_sclk, lcd_mosi, lcd_dc, lcd_csn, lcd_resn;
  logic [8:0]  exp_q[$];   // {dc, data} per display byte
  logic [8:0]  got_q[$];   // bytes seen on the display link
  line_cmd_t   lines[n_lines];
  logic [31:0] lfsr = 32'h85277bb4;
  logic [7:0]  rx_shift;
  int          rx_bits;
  int          errors, tests, tests_failed;
  int          watchdog_ns;

  line_lcd_top #(.clk_div (clk_div)) u_line_lcd_top (
    .clk (clk), .reset (reset),
    .spi_csn (spi_csn), .spi_sclk (spi_sclk), .spi_mosi (spi_mosi),
    .busy (busy),
    .lcd_sclk (lcd_sclk), .lcd_mosi (lcd_mosi), .lcd_dc (lcd_dc),
    .lcd_csn (lcd_csn), .lcd_resn (lcd_resn)
  );

  always #5 clk = ~clk;   // 100 MHz

  // ************************************************************
  // display link decoder, samples on rising lcd_sclk
  always @(posedge lcd_sclk)
  begin
    if (!reset && !lcd_csn)
    begin
      rx_shift = {rx_shift[6:0], lcd_mosi};   // msb first
      rx_bits  = rx_bits + 1;
      if (rx_bits == 8)
      begin
        got_q.push_back({lcd_dc, rx_shift});
        rx_bits = 0;
      end
    end
  end

  // link may only be active inside a plot
  always @(posedge clk)
  begin
    if (!reset)
      assert (lcd_csn || busy)
      else
      begin
        $display("display byte on the link while busy was low at %0t", $time);
        errors++;
      end
  end

  // ************************************************************
  // stimulus helpers
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // x^32+x^22+x^2+x+1
  endfunction

  task automatic rand_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v    = (v << 1) | int'(lfsr[0]);   // one step per bit
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // mode 0 host frame, start address then nbytes from the top of payload
  task automatic host_write(input logic [7:0] addr, input line_cmd_t payload, input int nbytes);
    logic [87:0] frame;
    frame = {addr, payload};
    @(posedge clk);
    spi_csn <= 1'b0;
    for (int k = 0; k < 8 * (nbytes + 1); k++)
    begin
      repeat (4) @(posedge clk);
      spi_sclk <= 1'b0;
      spi_mosi <= frame[87];
      frame = {frame[86:0], 1'b0};
      repeat (4) @(posedge clk);
      spi_sclk <= 1'b1;            // slave samples here
    end
    repeat (4) @(posedge clk);
    spi_sclk <= 1'b0;
    repeat (8) @(posedge clk);     // last strobe lands
    spi_csn <= 1'b1;
    repeat (8) @(posedge clk);
  endtask

  // ************************************************************
  // reference model, bresenham split into runs
  task automatic push_word(input logic [15:0] w);
    exp_q.push_back({1'b1, w[15:8]});
    exp_q.push_back({1'b1, w[7:0]});
  endtask

  task automatic emit_run(input logic x_major, input int maj, input int mnr, input int len,
                          input logic [15:0] color);
    int xs, ys, xe, ye;
    xs = x_major ? maj : mnr;
    ys = x_major ? mnr : maj;
    xe = x_major ? xs + len - 1 : xs;
    ye = x_major ? ys : ys + len - 1;
    exp_q.push_back({1'b0, 8'h2A});   // caset
    push_word(16'(xs));
    push_word(16'(xe));
    exp_q.push_back({1'b0, 8'h2B});   // raset
    push_word(16'(ys));
    push_word(16'(ye));
    exp_q.push_back({1'b0, 8'h2C});   // ramwr
    for (int i = 0; i < len; i++)
      push_word(color);
  endtask

  task automatic build_expected(input line_cmd_t c);
    int   x0, y0, x1, y1, dx, dy, t;
    int   maj, mnr, dmaj, dmin, step, d;
    int   run_maj, run_mnr, run_len;
    logic x_major;
    exp_q.delete();
    x0 = int'(c.x0);
    y0 = int'(c.y0);
    x1 = int'(c.x1);
    y1 = int'(c.y1);
    dx = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy = (y1 > y0) ? y1 - y0 : y0 - y1;
    x_major = (dx >= dy);                    // ties horizontal
    if (x_major ? (x1 < x0) : (y1 < y0))
    begin
      t  = x0;
      x0 = x1;
      x1 = t;
      t  = y0;
      y0 = y1;
      y1 = t;
    end
    maj  = x_major ? x0 : y0;
    mnr  = x_major ? y0 : x0;
    dmaj = x_major ? dx : dy;
    dmin = x_major ? dy : dx;
    step = x_major ? ((y1 < y0) ? -1 : 1) : ((x1 < x0) ? -1 : 1);
    d    = 2 * dmin - dmaj;
    run_maj = maj;
    run_mnr = mnr;
    run_len = 0;
    for (int i = 0; i <= dmaj; i++)
    begin
      if (mnr != run_mnr)                    // minor stepped, close run
      begin
        emit_run(x_major, run_maj, run_mnr, run_len, c.color);
        run_maj = maj + i;
        run_mnr = mnr;
        run_len = 0;
      end
      run_len = run_len + 1;
      if (d > 0)
      begin
        mnr = mnr + step;
        d   = d - 2 * dmaj;
      end
      d = d + 2 * dmin;
    end
    emit_run(x_major, run_maj, run_mnr, run_len, c.color);
  endtask

  // ************************************************************
  // checks and reporting
  task automatic wait_busy(input logic level, input int limit, input string name);
    int n;
    n = 0;
    while ((busy !== level) && (n < limit))
    begin
      @(posedge clk);
      n++;
    end
    assert (busy === level)
    else
    begin
      $display("%s: timed out waiting for busy to go %0b", name, level);
      errors++;
    end
  endtask

  task automatic compare_stream(input string name);
    int n, first_bad;
    first_bad = -1;
    assert (got_q.size() == exp_q.size())
    else
    begin
      $display("mismatch %s byte count expected %0d actual %0d", name, exp_q.size(),
               got_q.size());
      errors++;
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++)
      if ((first_bad < 0) && (got_q[i] !== exp_q[i]))
        first_bad = i;
    assert (first_bad < 0)
    else
    begin
      $display("mismatch %s byte %0d expected %h actual %h", name, first_bad,
               exp_q[first_bad], got_q[first_bad]);
      errors++;
    end
  endtask

  // pixel words on the link against the major span
  task automatic check_pixel_total(input string name, input line_cmd_t c);
    int runs, data_bytes, span_x, span_y, want, got;
    runs       = 0;
    data_bytes = 0;
    for (int i = 0; i < got_q.size(); i++)
    begin
      if (got_q[i] == {1'b0, 8'h2A})
        runs++;
      else if (got_q[i][8])
        data_bytes++;
    end
    span_x = (c.x1 > c.x0) ? int'(c.x1) - int'(c.x0) : int'(c.x0) - int'(c.x1);
    span_y = (c.y1 > c.y0) ? int'(c.y1) - int'(c.y0) : int'(c.y0) - int'(c.y1);
    want   = ((span_x > span_y) ? span_x : span_y) + 1;
    got    = (data_bytes - 8 * runs) / 2;   // 8 window arg bytes per run
    assert (got == want)
    else
    begin
      $display("mismatch %s pixel total expected %0d actual %0d", name, want, got);
      errors++;
    end
  endtask

  task automatic draw_and_compare(input string name, input line_cmd_t c);
    build_expected(c);
    got_q.delete();
    host_write(8'd0, c, 10);
    wait_busy(1'b1, 100, name);
    wait_busy(1'b0, exp_q.size() * byte_cycles + 200, name);
    compare_stream(name);
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    if (errors == e0)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - e0);
    end
  endtask

  // ************************************************************
  // line list, fixed cases then lfsr lines then the busy scenario
  task automatic make_lines();
    int a, b, c0, d, col, dx, dy, t;
    lines[0] = {16'd10, 16'd20, 16'd40, 16'd20, 16'hf800};
    lines[1] = {16'd7, 16'd50, 16'd7, 16'd5, 16'h07e0};   // reversed endpoints
    lines[2] = {16'd0, 16'd0, 16'd5, 16'd5, 16'h001f};
    for (int k = 0; k < 8; k++)
    begin
      rand_bits(6, a);
      rand_bits(6, b);
      rand_bits(6, c0);
      rand_bits(6, d);
      rand_bits(16, col);
      dx = (b > a) ? b - a : a - b;
      dy = (d > c0) ? d - c0 : c0 - d;
      if ((dy > dx) != (k % 2 == 1))   // odd lines steep, transpose
      begin
        t  = a;
        a  = c0;
        c0 = t;
        t  = b;
        b  = d;
        d  = t;
      end
      lines[3 + k] = {16'(a), 16'(c0), 16'(b), 16'(d), 16'(col)};
    end
    lines[11] = {16'd0, 16'd0, 16'd30, 16'd12, 16'hffe0};
    lines[12] = {16'd3, 16'd40, 16'd20, 16'd41, 16'h1234};
    lines[13] = lines[12];
    lines[13].color[7:0] = 8'h5a;
  endtask

  task automatic reset_state();
    int e0;
    e0 = errors;
    repeat (50) @(posedge clk);
    assert (busy === 1'b0)
    else
    begin
      $display("mismatch reset_state busy expected 0 actual %b", busy);
      errors++;
    end
    assert ((lcd_csn === 1'b1) && (lcd_sclk === 1'b1))
    else
    begin
      $display("mismatch reset_state csn/sclk expected 11 actual %b%b", lcd_csn, lcd_sclk);
      errors++;
    end
    assert (got_q.size() == 0)
    else
    begin
      $display("mismatch reset_state bytes expected 0 actual %0d", got_q.size());
      errors++;
    end
    report_test("reset_state", e0);
  endtask

  task automatic random_lines();
    int e0;
    e0 = errors;
    for (int k = 0; k < 8; k++)
    begin
      draw_and_compare($sformatf("random_line_%0d", k), lines[3 + k]);
      check_pixel_total($sformatf("random_line_%0d", k), lines[3 + k]);
    end
    report_test("random_lines", e0);
  endtask

  task automatic busy_behavior();
    int e0;
    e0 = errors;
    build_expected(lines[11]);
    got_q.delete();
    host_write(8'd0, lines[11], 10);
    wait_busy(1'b1, 100, "busy_behavior");
    host_write(8'd0, lines[12], 10);   // lands mid plot, plot dropped
    assert (busy === 1'b1)
    else
    begin
      $display("busy_behavior: plot ended before the second frame was written");
      errors++;
    end
    wait_busy(1'b0, exp_q.size() * byte_cycles + 200, "busy_behavior");
    assert (lcd_csn === 1'b1)
    else
    begin
      $display("busy_behavior: busy fell while a display byte was still shifting");
      errors++;
    end
    compare_stream("busy_behavior");
    repeat (200) @(posedge clk);
    assert ((busy === 1'b0) && (got_q.size() == exp_q.size()))
    else
    begin
      $display("busy_behavior: the frame written during the plot started a new window");
      errors++;
    end
    // replot by writing only the color low byte at address 9
    build_expected(lines[13]);
    got_q.delete();
    host_write(8'd9, line_cmd_t'({lines[13].color[7:0], 72'h0}), 1);
    wait_busy(1'b1, 100, "busy_replot");
    wait_busy(1'b0, exp_q.size() * byte_cycles + 200, "busy_replot");
    compare_stream("busy_replot");
    report_test("busy_behavior", e0);
  endtask

  // ************************************************************
  initial
  begin
    int e0;
    int budget;
    clk          = 1'b0;
    reset        = 1'b1;
    spi_csn      = 1'b1;
    spi_sclk     = 1'b0;   // mode 0 idle
    spi_mosi     = 1'b0;
    rx_shift     = '0;
    rx_bits      = 0;
    errors       = 0;
    tests        = 0;
    tests_failed = 0;
    make_lines();
    budget = 5000;
    for (int k = 0; k < n_lines; k++)
    begin
      build_expected(lines[k]);
      budget = budget + exp_q.size() * byte_cycles + 1000;   // link time plus host frame
    end
    watchdog_ns = 10 * budget;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    reset_state();
    e0 = errors;
    draw_and_compare("horizontal_line", lines[0]);
    report_test("horizontal_line", e0);
    e0 = errors;
    draw_and_compare("vertical_line", lines[1]);
    report_test("vertical_line", e0);
    e0 = errors;
    draw_and_compare("diagonal_line", lines[2]);
    report_test("diagonal_line", e0);
    random_lines();
    busy_behavior();

    $display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // hard stop sized from the line list
  initial
  begin
    #1;
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, a test hung", watchdog_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: compile.f
rtl/line_lcd_pkg.sv
rtl/spi_reg_slave.sv
rtl/line_regs.sv
rtl/draw_line.sv
rtl/lcd_spi_tx.sv
rtl/lcd_hvline.sv
rtl/line_lcd_top.sv
tb/line_lcd_checker.sv
tb/tb_line_lcd.sv

// File: run.sh
#!/bin/sh
# build and run the line_lcd testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_line_lcd -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_line_lcd)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '=== PASS ==='; then
  exit 0
fi
exit 1
